//--- verilog.f
rtl/icache_pkg.sv
rtl/icache_addr_decode.sv
rtl/icache_way_array.sv
rtl/icache_refill_ctrl.sv
rtl/icache_fetch_pack.sv
rtl/icache_top.sv
tb/icache_bus_mem.sv
tb/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_addr_decode.sv
  - rtl/icache_way_array.sv
  - rtl/icache_refill_ctrl.sv
  - rtl/icache_fetch_pack.sv
  - rtl/icache_top.sv
  - target: test
    files:
      - tb/icache_bus_mem.sv
      - tb/icache_tb.sv

//--- tb/icache_tb.sv
`default_nettype none
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

    localparam int N_RAND     = 400;
    localparam int N_DIRECTED = 16;

    logic          clk;
    logic          rst_n;
    logic          flush;
    logic          fetch_valid;
    fetch_req_t    fetch_req;
    logic          fetch_ready;
    logic          bundle_valid;
    fetch_bundle_t bundle;
    logic          maint_valid;
    maint_req_t    maint_req;
    logic          maint_ready;
    logic          bus_addr_valid;
    paddr_t        bus_addr;
    bus_len_t      bus_len;
    logic          bus_resp_ready;
    logic          bus_data_valid;
    inst_t         bus_data;
    int            req_cnt;
    paddr_t        last_addr;
    bus_len_t      last_len;

    // cache model state
    tag_t m_tag   [128][2];
    logic m_valid [128][2];
    logic m_rr    [128];

    icache_top #(.WAY_NUM(2), .SET_NUM(128)) icache_top_i (
        .clk, .rst_n,
        .flush_i          (flush),
        .fetch_valid_i    (fetch_valid),
        .fetch_req_i      (fetch_req),
        .fetch_ready_o    (fetch_ready),
        .bundle_valid_o   (bundle_valid),
        .bundle_o         (bundle),
        .maint_valid_i    (maint_valid),
        .maint_req_i      (maint_req),
        .maint_ready_o    (maint_ready),
        .bus_addr_valid_o (bus_addr_valid),
        .bus_addr_o       (bus_addr),
        .bus_len_o        (bus_len),
        .bus_resp_ready_i (bus_resp_ready),
        .bus_data_valid_i (bus_data_valid),
        .bus_data_i       (bus_data)
    );

    icache_bus_mem icache_bus_mem_i (
        .clk, .rst_n,
        .bus_addr_valid_i (bus_addr_valid),
        .bus_addr_i       (bus_addr),
        .bus_len_i        (bus_len),
        .bus_resp_ready_o (bus_resp_ready),
        .bus_data_valid_o (bus_data_valid),
        .bus_data_o       (bus_data),
        .req_cnt_o        (req_cnt),
        .last_addr_o      (last_addr),
        .last_len_o       (last_len)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic inst_t expected_word(input paddr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // way holding the line of pc, -1 when absent or uncached
    function automatic int resident_way(input paddr_t pc);
        int way;
        way = -1;
        if (pc[31:28] != 4'hA) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[pc[11:5]][w] && (m_tag[pc[11:5]][w] == pc[31:12])) begin
                    way = w;
                end
            end
        end
        return way;
    endfunction

    task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp);
        if (got.pc !== exp.pc || got.mask !== exp.mask || got.predict !== exp.predict) begin
            stop_on_error($sformatf("FAIL bundle_o pc/mask/predict got %h/%h/%h exp %h/%h/%h",
                got.pc, got.mask, got.predict, exp.pc, exp.mask, exp.predict));
        end
        // lanes outside the mask carry no meaning
        for (int lane = 0; lane < 2; lane++) begin
            if (exp.mask[lane] && (got.insts[lane] !== exp.insts[lane])) begin
                stop_on_error($sformatf("FAIL bundle_o.insts[%0d] got %h exp %h",
                    lane, got.insts[lane], exp.insts[lane]));
            end
        end
    endtask

    task automatic check_bus_req(input paddr_t got_addr, input bus_len_t got_len,
                                 input paddr_t exp_addr, input bus_len_t exp_len);
        if (got_addr !== exp_addr || got_len !== exp_len) begin
            stop_on_error($sformatf("FAIL bus_addr_o/bus_len_o got %h/%h exp %h/%h",
                got_addr, got_len, exp_addr, exp_len));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("FAIL bundle_valid_o latency got %h exp %h", got, exp));
        end
    endtask

    task automatic run_fetch(input paddr_t pc, input lane_mask_t mask, input logic do_flush);
        fetch_req_t    req;
        fetch_bundle_t exp;
        logic          cached;
        int            way;
        int            n_before;
        int            lat;
        int            last_beat;
        req      = '{pc: pc, mask: mask, predict: 8'($urandom)};
        cached   = (pc[31:28] != 4'hA);
        way      = resident_way(pc);
        n_before = req_cnt;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_req   = req;
        do begin
            @(posedge clk);
        end while (!fetch_ready);
        @(negedge clk);
        fetch_valid = 1'b0;
        flush       = do_flush;
        lat         = 1;
        @(posedge clk);
        if (do_flush || mask == 2'b00) begin
            if (bundle_valid) begin
                stop_on_error($sformatf("FAIL bundle_valid_o got %h exp %h",
                    bundle_valid, 1'b0));
            end
            @(negedge clk);
            flush = 1'b0;
            repeat (2) begin
                @(posedge clk);
                if (bundle_valid) begin
                    stop_on_error($sformatf("FAIL bundle_valid_o got %h exp %h",
                        bundle_valid, 1'b0));
                end
            end
            if (req_cnt != n_before) begin
                stop_on_error("bus request issued for a flushed or empty fetch");
            end
        end else begin
            last_beat = 0;
            while (!bundle_valid) begin
                if (bus_data_valid) begin
                    last_beat = lat;
                end
                @(posedge clk);
                lat++;
            end
            // fetch side reopens with the bundle
            if (!fetch_ready) begin
                stop_on_error($sformatf("FAIL fetch_ready_o got %h exp %h",
                    fetch_ready, 1'b1));
            end
            exp.pc       = pc;
            exp.mask     = mask;
            exp.predict  = req.predict;
            exp.insts[0] = expected_word(pc);
            exp.insts[1] = expected_word(pc + 32'd4);
            check_bundle(bundle, exp);
            if (way >= 0) begin
                check_latency(lat, 1);
                if (req_cnt != n_before) begin
                    stop_on_error("bus request issued on a cache hit");
                end
            end else begin
                check_latency(lat - last_beat, 1);
                if (req_cnt != n_before + 1) begin
                    stop_on_error("a miss did not issue exactly one bus request");
                end
                if (cached) begin
                    check_bus_req(last_addr, last_len, {pc[31:5], 5'b0}, 4'd8);
                    // refill goes to the round-robin victim
                    m_tag[pc[11:5]][m_rr[pc[11:5]]]   = pc[31:12];
                    m_valid[pc[11:5]][m_rr[pc[11:5]]] = 1'b1;
                    m_rr[pc[11:5]]                    = ~m_rr[pc[11:5]];
                end else begin
                    check_bus_req(last_addr, last_len, mask[0] ? pc : pc + 32'd4,
                                  bus_len_t'($countones(mask)));
                end
            end
        end
    endtask

    task automatic run_invalidate(input set_idx_t set, input logic way);
        @(negedge clk);
        while (!maint_ready) @(negedge clk);
        maint_valid = 1'b1;
        maint_req   = '{set: set, way: way};
        @(negedge clk);
        maint_valid = 1'b0;
        m_valid[set][way] = 1'b0;
    endtask

    initial begin
        repeat (16 + (N_RAND + N_DIRECTED) * 200) @(posedge clk);
        stop_on_error("watchdog expired before all fetches completed");
    end

    initial begin
        paddr_t pc;
        int     way;
        void'($urandom(32'h0608a1e9));
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        maint_valid = 1'b0;
        maint_req   = '0;
        for (int s = 0; s < 128; s++) begin
            m_rr[s]       = 1'b0;
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        if (!fetch_ready || !maint_ready) begin
            stop_on_error($sformatf("FAIL fetch_ready_o/maint_ready_o got %h/%h exp 1/1",
                fetch_ready, maint_ready));
        end
        if (bundle_valid || bus_addr_valid) begin
            stop_on_error($sformatf("FAIL bundle_valid_o/bus_addr_valid_o got %h/%h exp 0/0",
                bundle_valid, bus_addr_valid));
        end

        // miss then repeat hit
        run_fetch({20'h00055, 7'd102, 5'h18}, 2'b11, 1'b0);
        run_fetch({20'h00055, 7'd102, 5'h18}, 2'b11, 1'b0);
        // third tag in one set evicts the oldest line
        run_fetch({20'h00011, 7'd100, 5'h08}, 2'b11, 1'b0);
        run_fetch({20'h00022, 7'd100, 5'h08}, 2'b01, 1'b0);
        run_fetch({20'h00033, 7'd100, 5'h08}, 2'b10, 1'b0);
        run_fetch({20'h00011, 7'd100, 5'h08}, 2'b11, 1'b0);
        // uncached space never allocates
        run_fetch(32'hA000_0128, 2'b10, 1'b0);
        run_fetch(32'hA000_0128, 2'b10, 1'b0);
        run_fetch(32'hA000_0128, 2'b01, 1'b0);
        run_fetch(32'hA000_0128, 2'b11, 1'b0);
        // invalidate then refetch
        pc = {20'h00044, 7'd101, 5'h10};
        run_fetch(pc, 2'b11, 1'b0);
        way = resident_way(pc);
        run_invalidate(pc[11:5], 1'(way));
        run_fetch(pc, 2'b11, 1'b0);
        // flushed and empty fetches to a resident line
        run_fetch({20'h00033, 7'd100, 5'h08}, 2'b11, 1'b1);
        run_fetch({20'h00033, 7'd100, 5'h08}, 2'b00, 1'b0);
        run_fetch({20'h00033, 7'd100, 5'h08}, 2'b11, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            pc = {(($urandom_range(7) == 0) ? 4'hA : 4'h0), 14'h0, 2'($urandom_range(3)),
                  7'($urandom_range(7) * 9), 2'($urandom_range(3)), 3'b000};
            run_fetch(pc, 2'($urandom), ($urandom_range(15) == 0));
            if ($urandom_range(31) == 0) begin
                run_invalidate(7'($urandom_range(7) * 9), 1'($urandom));
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/icache_bus_mem.sv
`default_nettype none
`timescale 1ns/10ps

module icache_bus_mem import icache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     bus_addr_valid_i,
    input  paddr_t   bus_addr_i,
    input  bus_len_t bus_len_i,
    output logic     bus_resp_ready_o,
    output logic     bus_data_valid_o,
    output inst_t    bus_data_o,
    output int       req_cnt_o,
    output paddr_t   last_addr_o,
    output bus_len_t last_len_o
);

    paddr_t   next_addr;
    bus_len_t beats_left;
    logic     req_seen;
    paddr_t   req_addr;
    bus_len_t req_len;

    // memory content is a fixed mix of the whole word address
    function automatic inst_t word_at(input paddr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    initial begin
        bus_resp_ready_o = 1'b0;
        bus_data_valid_o = 1'b0;
        bus_data_o       = '0;
    end

    // request lines are settled at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            req_seen <= 1'b0;
        end else begin
            req_seen <= bus_addr_valid_i;
        end
        req_addr <= bus_addr_i;
        req_len  <= bus_len_i;
    end

    // responses change on the falling edge, with random gaps
    always @(negedge clk) begin
        if (!rst_n) begin
            bus_resp_ready_o <= 1'b0;
            bus_data_valid_o <= 1'b0;
            beats_left       <= '0;
            req_cnt_o        <= 0;
        end else begin
            bus_resp_ready_o <= 1'b0;
            bus_data_valid_o <= 1'b0;
            if (beats_left != 0) begin
                if ($urandom_range(3) != 0) begin
                    bus_data_valid_o <= 1'b1;
                    bus_data_o       <= word_at(next_addr);
                    next_addr        <= next_addr + 32'd4;
                    beats_left       <= beats_left - 4'd1;
                end
            end else if (req_seen && ($urandom_range(1) == 0)) begin
                // request taken at the next rising edge
                bus_resp_ready_o <= 1'b1;
                next_addr        <= req_addr;
                beats_left       <= req_len;
                last_addr_o      <= req_addr;
                last_len_o       <= req_len;
                req_cnt_o        <= req_cnt_o + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`default_nettype none
`timescale 1ns/10ps

module icache_top import icache_pkg::*; #(
    parameter int unsigned WAY_NUM = 2,
    parameter int unsigned SET_NUM = 128
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush_i,
    input  logic          fetch_valid_i,
    input  fetch_req_t    fetch_req_i,
    output logic          fetch_ready_o,
    output logic          bundle_valid_o,
    output fetch_bundle_t bundle_o,
    input  logic          maint_valid_i,
    input  maint_req_t    maint_req_i,
    output logic          maint_ready_o,
    output logic          bus_addr_valid_o,
    output paddr_t        bus_addr_o,
    output bus_len_t      bus_len_o,
    input  logic          bus_resp_ready_i,
    input  logic          bus_data_valid_i,
    input  inst_t         bus_data_i
);

    fetch_req_t               req_q;
    logic                     req_valid_q;
    tag_t                     tag;
    set_idx_t                 set;
    pair_sel_t                pair;
    logic                     uncached;
    tag_entry_t [WAY_NUM-1:0] way_tag;
    inst_t [WAY_NUM-1:0][1:0] way_pair;
    logic [WAY_NUM-1:0]       tag_we;
    logic [WAY_NUM-1:0]       data_we;
    tag_entry_t               wr_tag;
    data_addr_t               wr_data_addr;
    inst_t [1:0]              wr_data;
    logic                     hit_way;
    out_cause_t               out_cause;
    inst_t [1:0]              fill_pair;

    icache_addr_decode icache_addr_decode_i (
        .clk, .rst_n, .flush_i,
        .fetch_valid_i,
        .fetch_ready_i (fetch_ready_o),
        .fetch_req_i,
        .req_q_o       (req_q),
        .req_valid_q_o (req_valid_q),
        .tag_o         (tag),
        .set_o         (set),
        .pair_o        (pair),
        .uncached_o    (uncached)
    );

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        icache_way_array #(.SET_NUM(SET_NUM)) icache_way_array_i (
            .clk, .rst_n,
            .rd_en_i        (fetch_valid_i && fetch_ready_o),
            .rd_set_i       (set),
            .rd_pair_i      (pair),
            .tag_we_i       (tag_we[w]),
            .wr_tag_i       (wr_tag),
            .wr_tag_set_i   (wr_data_addr.set),
            .data_we_i      (data_we[w]),
            .wr_data_addr_i (wr_data_addr),
            .wr_data_i      (wr_data),
            .tag_o          (way_tag[w]),
            .pair_o         (way_pair[w])
        );
    end

    icache_refill_ctrl #(.WAY_NUM(WAY_NUM), .SET_NUM(SET_NUM)) icache_refill_ctrl_i (
        .clk, .rst_n, .flush_i,
        .req_valid_q_i  (req_valid_q),
        .tag_i          (tag),
        .set_i          (set),
        .pair_i         (pair),
        .uncached_i     (uncached),
        .mask_i         (req_q.mask),
        .way_tag_i      (way_tag),
        .maint_valid_i, .maint_req_i, .maint_ready_o,
        .fetch_ready_o,
        .bus_addr_valid_o, .bus_addr_o, .bus_len_o,
        .bus_resp_ready_i, .bus_data_valid_i, .bus_data_i,
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .wr_tag_o       (wr_tag),
        .wr_data_addr_o (wr_data_addr),
        .wr_data_o      (wr_data),
        .hit_way_o      (hit_way),
        .out_cause_o    (out_cause),
        .fill_pair_o    (fill_pair)
    );

    icache_fetch_pack #(.WAY_NUM(WAY_NUM)) icache_fetch_pack_i (
        .clk, .rst_n, .flush_i,
        .req_q_i        (req_q),
        .out_cause_i    (out_cause),
        .hit_way_i      (hit_way),
        .way_pair_i     (way_pair),
        .fill_pair_i    (fill_pair),
        .bundle_valid_o,
        .bundle_o
    );

endmodule

`default_nettype wire

//--- rtl/icache_fetch_pack.sv
`default_nettype none
`timescale 1ns/10ps

module icache_fetch_pack import icache_pkg::*; #(
    parameter int unsigned WAY_NUM = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  fetch_req_t                req_q_i,
    input  out_cause_t                out_cause_i,
    input  logic                      hit_way_i,
    input  inst_t [WAY_NUM-1:0][1:0]  way_pair_i,
    input  inst_t [1:0]               fill_pair_i,
    output logic                      bundle_valid_o,
    output fetch_bundle_t             bundle_o
);

    logic fill_q;

    // refill bundle goes out the cycle after its last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_q <= 1'b0;
        end else begin
            fill_q <= (out_cause_i == CAUSE_FILL) && !flush_i;
        end
    end

    always_comb begin
        bundle_o.pc      = req_q_i.pc;
        bundle_o.mask    = req_q_i.mask;
        bundle_o.predict = req_q_i.predict;
        bundle_o.insts   = fill_q ? fill_pair_i : way_pair_i[hit_way_i];
    end

    // empty mask or flush kills the strobe
    assign bundle_valid_o = ((out_cause_i == CAUSE_HIT) || fill_q)
                            && (|req_q_i.mask) && !flush_i;

endmodule

`default_nettype wire

//--- rtl/icache_refill_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module icache_refill_ctrl import icache_pkg::*; #(
    parameter int unsigned WAY_NUM = 2,
    parameter int unsigned SET_NUM = 128
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  logic                      req_valid_q_i,
    input  tag_t                      tag_i,
    input  set_idx_t                  set_i,
    input  pair_sel_t                 pair_i,
    input  logic                      uncached_i,
    input  lane_mask_t                mask_i,
    input  tag_entry_t [WAY_NUM-1:0]  way_tag_i,
    input  logic                      maint_valid_i,
    input  maint_req_t                maint_req_i,
    output logic                      maint_ready_o,
    output logic                      fetch_ready_o,
    output logic                      bus_addr_valid_o,
    output paddr_t                    bus_addr_o,
    output bus_len_t                  bus_len_o,
    input  logic                      bus_resp_ready_i,
    input  logic                      bus_data_valid_i,
    input  inst_t                     bus_data_i,
    output logic [WAY_NUM-1:0]        tag_we_o,
    output logic [WAY_NUM-1:0]        data_we_o,
    output tag_entry_t                wr_tag_o,
    output data_addr_t                wr_data_addr_o,
    output inst_t [1:0]               wr_data_o,
    output logic                      hit_way_o,
    output out_cause_t                out_cause_o,
    output inst_t [1:0]               fill_pair_o
);

    localparam int unsigned SET_W = $clog2(SET_NUM);

    ic_state_e          state_q, state_d;
    logic [2:0]         cnt_q;
    logic [SET_NUM-1:0] rr_q;
    logic               resume_q;
    inst_t              low_q;
    inst_t [1:0]        fill_pair_q;

    logic [WAY_NUM-1:0] hit_vec;
    logic               need_bus;
    logic               pending;
    logic               victim;
    logic               unc_last;
    logic               fill_done;

    always_comb begin
        hit_vec   = '0;
        hit_way_o = 1'b0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_vec[w] = way_tag_i[w].valid && (way_tag_i[w].tag == tag_i);
            if (hit_vec[w]) begin
                hit_way_o = 1'(w);
            end
        end
    end

    // the held request is stale until a new fetch slot opens after a refill
    assign pending  = req_valid_q_i && !resume_q;
    assign need_bus = (state_q == LOOKUP) && pending && !flush_i && (|mask_i)
                      && (uncached_i || !(|hit_vec));

    assign maint_ready_o = (state_q == LOOKUP) && !pending;
    assign fetch_ready_o = (state_q == LOOKUP) && !need_bus && !maint_valid_i;

    assign victim    = rr_q[set_i[SET_W-1:0]];
    assign unc_last  = (mask_i != 2'b11) || cnt_q[0];
    assign fill_done = (state_q inside {MISS_DATA, UNC_DATA}) && (state_d == LOOKUP);

    always_comb begin
        state_d          = state_q;
        bus_addr_valid_o = 1'b0;
        bus_addr_o       = {tag_i, set_i, 5'b0};
        bus_len_o        = bus_len_t'(LINE_WORDS);
        tag_we_o         = '0;
        data_we_o        = '0;
        wr_tag_o         = '{valid: 1'b1, tag: tag_i};
        wr_data_addr_o   = '{set: set_i, pair: cnt_q[2:1]};
        wr_data_o        = {bus_data_i, low_q};
        out_cause_o      = CAUSE_NONE;
        // uncached: first masked word, one beat per lane
        if (uncached_i) begin
            bus_addr_o = {tag_i, set_i, pair_i, ~mask_i[0], 2'b00};
            bus_len_o  = (mask_i == 2'b11) ? 4'd2 : 4'd1;
        end
        unique case (state_q)
            LOOKUP: begin
                if (maint_valid_i && maint_ready_o) begin
                    tag_we_o[maint_req_i.way] = 1'b1;
                    wr_tag_o                  = '{valid: 1'b0, tag: '0};
                    wr_data_addr_o.set        = maint_req_i.set;
                end else if (need_bus) begin
                    bus_addr_valid_o = 1'b1;
                    if (uncached_i) begin
                        state_d = bus_resp_ready_i ? UNC_DATA : UNC_REQ;
                    end else begin
                        state_d = bus_resp_ready_i ? MISS_DATA : MISS_REQ;
                    end
                end else if (pending) begin
                    out_cause_o = CAUSE_HIT;
                end
            end
            MISS_REQ, UNC_REQ: begin
                bus_addr_valid_o = 1'b1;
                if (bus_resp_ready_i) begin
                    state_d = (state_q == MISS_REQ) ? MISS_DATA : UNC_DATA;
                end
            end
            MISS_DATA: begin
                // odd beat completes a pair
                if (bus_data_valid_i && cnt_q[0]) begin
                    data_we_o[victim] = 1'b1;
                    if (cnt_q == 3'd7) begin
                        tag_we_o[victim] = 1'b1;
                        state_d          = LOOKUP;
                        if (req_valid_q_i) begin
                            out_cause_o = CAUSE_FILL;
                        end
                    end
                end
            end
            UNC_DATA: begin
                if (bus_data_valid_i && unc_last) begin
                    state_d = LOOKUP;
                    if (req_valid_q_i) begin
                        out_cause_o = CAUSE_FILL;
                    end
                end
            end
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= LOOKUP;
            cnt_q    <= '0;
            rr_q     <= '0;
            resume_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (fill_done) begin
                resume_q <= 1'b1;
            end else if (fetch_ready_o) begin
                resume_q <= 1'b0;
            end
            if (state_q == LOOKUP) begin
                cnt_q <= '0;
            end else if (bus_data_valid_i) begin
                cnt_q <= cnt_q + 3'd1;
            end
            // round-robin victim flips once per line fill
            if (fill_done && (state_q == MISS_DATA)) begin
                rr_q[set_i[SET_W-1:0]] <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_data_valid_i && (state_q == MISS_DATA)) begin
            if (!cnt_q[0]) begin
                low_q <= bus_data_i;
            end else if (cnt_q[2:1] == pair_i) begin
                fill_pair_q <= {bus_data_i, low_q};
            end
        end else if (bus_data_valid_i && (state_q == UNC_DATA)) begin
            fill_pair_q[cnt_q[0] ^ ~mask_i[0]] <= bus_data_i;
        end
    end

    assign fill_pair_o = fill_pair_q;

endmodule

`default_nettype wire

//--- rtl/icache_way_array.sv
`default_nettype none
`timescale 1ns/10ps

module icache_way_array import icache_pkg::*; #(
    parameter int unsigned SET_NUM = 128
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_en_i,
    input  set_idx_t    rd_set_i,
    input  pair_sel_t   rd_pair_i,
    input  logic        tag_we_i,
    input  tag_entry_t  wr_tag_i,
    input  set_idx_t    wr_tag_set_i,
    input  logic        data_we_i,
    input  data_addr_t  wr_data_addr_i,
    input  inst_t [1:0] wr_data_i,
    output tag_entry_t  tag_o,
    output inst_t [1:0] pair_o
);

    localparam int unsigned SET_W = $clog2(SET_NUM);

    logic [SET_NUM-1:0] valid_q;
    tag_t               tag_mem [SET_NUM];
    inst_t [1:0]        data_mem [SET_NUM*4];

    logic               rd_valid_q;
    tag_t               rd_tag_q;
    logic [SET_W-1:0]   rd_idx;
    logic [SET_W-1:0]   wr_idx;

    assign rd_idx = rd_set_i[SET_W-1:0];
    assign wr_idx = wr_tag_set_i[SET_W-1:0];

    // valid bits live in flops so reset can clear them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (tag_we_i) begin
                valid_q[wr_idx] <= wr_tag_i.valid;
            end
            if (rd_en_i) begin
                rd_valid_q <= valid_q[rd_idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[wr_idx] <= wr_tag_i.tag;
        end
        if (data_we_i) begin
            data_mem[{wr_data_addr_i.set[SET_W-1:0], wr_data_addr_i.pair}] <= wr_data_i;
        end
        // one-cycle read port
        if (rd_en_i) begin
            rd_tag_q <= tag_mem[rd_idx];
            pair_o   <= data_mem[{rd_idx, rd_pair_i}];
        end
    end

    assign tag_o = '{valid: rd_valid_q, tag: rd_tag_q};

endmodule

`default_nettype wire

//--- rtl/icache_addr_decode.sv
`default_nettype none
`timescale 1ns/10ps

module icache_addr_decode import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush_i,
    input  logic       fetch_valid_i,
    input  logic       fetch_ready_i,
    input  fetch_req_t fetch_req_i,
    output fetch_req_t req_q_o,
    output logic       req_valid_q_o,
    output tag_t       tag_o,
    output set_idx_t   set_o,
    output pair_sel_t  pair_o,
    output logic       uncached_o
);

    paddr_t idx_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid_q_o <= 1'b0;
        end else if (flush_i) begin
            req_valid_q_o <= 1'b0;
        end else if (fetch_ready_i) begin
            req_valid_q_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready_i && fetch_valid_i) begin
            req_q_o <= fetch_req_i;
        end
    end

    // incoming pc while accepting, else the held request
    assign idx_pc = fetch_ready_i ? fetch_req_i.pc : req_q_o.pc;
    assign set_o  = idx_pc[11:5];
    assign pair_o = idx_pc[4:3];

    assign tag_o      = req_q_o.pc[31:12];
    assign uncached_o = (req_q_o.pc[31:28] == UNCACHED_HI);

endmodule

`default_nettype wire

//--- rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  lane_mask_t;
    typedef logic [19:0] tag_t;       // pc[31:12]
    typedef logic [6:0]  set_idx_t;   // pc[11:5]
    typedef logic [1:0]  pair_sel_t;  // pc[4:3]
    typedef logic [3:0]  bus_len_t;
    typedef logic [1:0]  out_cause_t;

    localparam int unsigned LINE_WORDS = 8;
    // top nibble of the uncached window
    localparam logic [3:0] UNCACHED_HI = 4'hA;

    // why the bundle stage fires this cycle
    localparam out_cause_t CAUSE_NONE = 2'd0;
    localparam out_cause_t CAUSE_HIT  = 2'd1;
    localparam out_cause_t CAUSE_FILL = 2'd2;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        paddr_t     pc;
        lane_mask_t mask;
        logic [7:0] predict;
    } fetch_req_t;

    typedef struct packed {
        paddr_t      pc;
        inst_t [1:0] insts;
        lane_mask_t  mask;
        logic [7:0]  predict;
    } fetch_bundle_t;

    typedef struct packed {
        set_idx_t set;
        logic     way;
    } maint_req_t;

    // one word pair inside a set
    typedef struct packed {
        set_idx_t  set;
        pair_sel_t pair;
    } data_addr_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_REQ,
        MISS_DATA,
        UNC_REQ,
        UNC_DATA
    } ic_state_e;

endpackage

`default_nettype wire
